// ==== design/dma_sink_pkg.sv ====
// Assumes a stream exactly one RAM word wide and word aligned destination addresses.
`default_nettype none

package dma_sink_pkg;

    // stream and RAM geometry
    localparam int DATA_W = 32;
    localparam int KEEP_W = 4;
    localparam int ADDR_W = 16;
    localparam int WORD_ADDR_W = 14;

    // descriptor fields
    localparam int LEN_W = 16;
    localparam int TAG_W = 8;
    localparam int CYCLE_W = 15;

    // queue depths, the status queue also bounds the active transfers
    localparam int STATUS_FIFO_AW = 4;
    localparam int CMD_FIFO_AW = 4;

    typedef struct packed {
        logic [ADDR_W-1:0] dst_addr;
        logic [LEN_W-1:0]  len;
        logic [TAG_W-1:0]  tag;
    } desc_req_t;

    typedef struct packed {
        logic [LEN_W-1:0] len;
        logic [TAG_W-1:0] tag;
    } desc_sts_t;

    // cycle_count is beats minus one, last_offset is len mod KEEP_W
    typedef struct packed {
        logic [WORD_ADDR_W-1:0]    word_addr;
        logic [CYCLE_W-1:0]        cycle_count;
        logic [$clog2(KEEP_W)-1:0] last_offset;
        logic [TAG_W-1:0]          tag;
    } job_t;

    typedef struct packed {
        logic [WORD_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]      data;
        logic [KEEP_W-1:0]      be;
    } ram_cmd_t;

    typedef struct packed {
        logic [LEN_W-1:0] len;
        logic [TAG_W-1:0] tag;
        logic             last;
    } status_entry_t;

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_write = 2'd1,
        st_drop  = 2'd2
    } engine_state_e;

endpackage

`default_nettype wire

// ==== design/dma_desc_decode.sv ====
// One descriptor in decode at a time. The two low address bits are ignored.
`timescale 1ns/1ps
`default_nettype none

module dma_desc_decode (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    enable,
    input  wire dma_sink_pkg::desc_req_t desc_req,
    input  wire logic                    desc_valid,
    output logic                         desc_ready,
    input  wire logic                    slot_avail,
    input  wire logic                    engine_idle,
    output dma_sink_pkg::job_t           job,
    output logic                         job_valid
);

    logic                             pending;
    logic                             handshake;
    logic [dma_sink_pkg::LEN_W-1:0]   len_m1;

    assign handshake = desc_valid && desc_ready;
    assign len_m1 = desc_req.len - 1'b1;

    always_ff @(posedge clk) begin
        desc_ready <= enable && slot_avail && engine_idle && !pending && !handshake;
        job_valid <= handshake;

        if (handshake) begin
            pending <= 1'b1;
            job.word_addr <= desc_req.dst_addr[dma_sink_pkg::ADDR_W-1:
                                               dma_sink_pkg::ADDR_W-dma_sink_pkg::WORD_ADDR_W];
            job.cycle_count <= dma_sink_pkg::CYCLE_W'(len_m1 >> $clog2(dma_sink_pkg::KEEP_W));
            job.last_offset <= desc_req.len[$clog2(dma_sink_pkg::KEEP_W)-1:0];
            job.tag <= desc_req.tag;
        end else if (!engine_idle) begin
            // engine has left idle, so the job is taken
            pending <= 1'b0;
        end

        if (rst) begin
            desc_ready <= 1'b0;
            job_valid <= 1'b0;
            pending <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/dma_write_engine.sv ====
// Writes one RAM word per beat. Beats past the requested length are dropped up to tlast.
`timescale 1ns/1ps
`default_nettype none

module dma_write_engine (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire dma_sink_pkg::job_t                  job,
    input  wire logic                                job_valid,
    output logic                                     engine_idle,
    input  wire logic [dma_sink_pkg::DATA_W-1:0]     s_tdata,
    input  wire logic [dma_sink_pkg::KEEP_W-1:0]     s_tkeep,
    input  wire logic                                s_tlast,
    input  wire logic                                s_tvalid,
    output logic                                     s_tready,
    input  wire logic                                cmd_room,
    input  wire logic                                sts_room,
    output dma_sink_pkg::ram_cmd_t                   cmd,
    output logic                                     cmd_valid,
    output dma_sink_pkg::status_entry_t              entry,
    output logic                                     entry_we
);

    dma_sink_pkg::engine_state_e                     state, state_next;
    logic [dma_sink_pkg::WORD_ADDR_W-1:0]            addr, addr_next;
    logic [dma_sink_pkg::KEEP_W-1:0]                 keep_mask, keep_mask_next;
    logic [$clog2(dma_sink_pkg::KEEP_W)-1:0]         last_offset, last_offset_next;
    logic [dma_sink_pkg::LEN_W-1:0]                  length, length_next;
    logic [dma_sink_pkg::CYCLE_W-1:0]                cycle_count, cycle_count_next;
    logic [dma_sink_pkg::TAG_W-1:0]                  tag, tag_next;
    logic                                            s_tready_next;
    logic [dma_sink_pkg::KEEP_W-1:0]                 masked_keep;
    logic [dma_sink_pkg::LEN_W-1:0]                  cycle_size;
    logic                                            last_cycle;
    logic                                            beat;

    assign engine_idle = state == dma_sink_pkg::st_idle;
    assign last_cycle = cycle_count == '0;
    assign beat = s_tready && s_tvalid;
    assign masked_keep = s_tkeep & keep_mask;

    always_comb begin
        state_next = state;
        addr_next = addr;
        last_offset_next = last_offset;
        length_next = length;
        cycle_count_next = cycle_count;
        tag_next = tag;
        s_tready_next = 1'b0;

        // bytes below the first unused lane
        cycle_size = dma_sink_pkg::LEN_W'(dma_sink_pkg::KEEP_W);
        for (int i = dma_sink_pkg::KEEP_W - 1; i >= 0; i--) begin
            if (!masked_keep[i]) begin
                cycle_size = dma_sink_pkg::LEN_W'(i);
            end
        end

        cmd.addr = addr;
        cmd.data = s_tdata;
        cmd.be = masked_keep;
        cmd_valid = 1'b0;
        entry.len = length;
        entry.tag = tag;
        entry.last = 1'b0;
        entry_we = 1'b0;

        case (state)
            dma_sink_pkg::st_idle: begin
                if (job_valid) begin
                    addr_next = job.word_addr;
                    cycle_count_next = job.cycle_count;
                    last_offset_next = job.last_offset;
                    tag_next = job.tag;
                    length_next = '0;
                    s_tready_next = cmd_room && sts_room;
                    state_next = dma_sink_pkg::st_write;
                end
            end
            dma_sink_pkg::st_write: begin
                s_tready_next = cmd_room && sts_room;
                if (beat) begin
                    cmd_valid = 1'b1;
                    entry_we = 1'b1;
                    addr_next = addr + 1'b1;
                    length_next = length + dma_sink_pkg::LEN_W'(dma_sink_pkg::KEEP_W);
                    cycle_count_next = cycle_count - 1'b1;
                    if (s_tlast) begin
                        length_next = length + cycle_size;
                        entry.last = 1'b1;
                        s_tready_next = 1'b0;
                        state_next = dma_sink_pkg::st_idle;
                    end else if (last_cycle) begin
                        // length used up before tlast
                        if (last_offset != '0) begin
                            length_next = length + dma_sink_pkg::LEN_W'(last_offset);
                        end
                        entry.last = 1'b1;
                        s_tready_next = 1'b1;
                        state_next = dma_sink_pkg::st_drop;
                    end
                    entry.len = length_next;
                end
            end
            dma_sink_pkg::st_drop: begin
                s_tready_next = 1'b1;
                if (beat && s_tlast) begin
                    s_tready_next = 1'b0;
                    state_next = dma_sink_pkg::st_idle;
                end
            end
            default: begin
                state_next = dma_sink_pkg::st_idle;
            end
        endcase

        // trim only the final counted beat
        if (cycle_count_next == '0 && last_offset_next != '0) begin
            keep_mask_next = ~({dma_sink_pkg::KEEP_W{1'b1}} << last_offset_next);
        end else begin
            keep_mask_next = '1;
        end
    end

    always_ff @(posedge clk) begin
        state <= state_next;
        s_tready <= s_tready_next;
        addr <= addr_next;
        keep_mask <= keep_mask_next;
        last_offset <= last_offset_next;
        length <= length_next;
        cycle_count <= cycle_count_next;
        tag <= tag_next;

        if (rst) begin
            state <= dma_sink_pkg::st_idle;
            s_tready <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/dma_ram_write_port.sv ====
// Completions must come back in issue order, one ram_wr_done pulse per accepted command.
`timescale 1ns/1ps
`default_nettype none

module dma_ram_write_port (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire dma_sink_pkg::ram_cmd_t cmd,
    input  wire logic                   cmd_valid,
    output logic                        cmd_room,
    output dma_sink_pkg::ram_cmd_t      ram_cmd,
    output logic                        ram_cmd_valid,
    input  wire logic                   ram_cmd_ready,
    input  wire logic                   ram_wr_done,
    output logic                        done_pending,
    input  wire logic                   done_ack
);

    dma_sink_pkg::ram_cmd_t                 mem [2**dma_sink_pkg::CMD_FIFO_AW];
    logic [dma_sink_pkg::CMD_FIFO_AW:0]     wr_ptr, rd_ptr, level;
    logic [dma_sink_pkg::CMD_FIFO_AW:0]     done_count;
    logic                                   empty, full;

    assign level = wr_ptr - rd_ptr;
    assign empty = wr_ptr == rd_ptr;
    assign full = level[dma_sink_pkg::CMD_FIFO_AW];

    always_ff @(posedge clk) begin
        ram_cmd_valid <= ram_cmd_valid && !ram_cmd_ready;
        cmd_room <= level < 2**(dma_sink_pkg::CMD_FIFO_AW-1);

        if (cmd_valid && !full) begin
            mem[wr_ptr[dma_sink_pkg::CMD_FIFO_AW-1:0]] <= cmd;
            wr_ptr <= wr_ptr + 1'b1;
        end

        // refill the output register when it is free or being taken
        if (!empty && (!ram_cmd_valid || ram_cmd_ready)) begin
            ram_cmd <= mem[rd_ptr[dma_sink_pkg::CMD_FIFO_AW-1:0]];
            ram_cmd_valid <= 1'b1;
            rd_ptr <= rd_ptr + 1'b1;
        end

        if (ram_wr_done && !done_ack && done_count != '1) begin
            done_count <= done_count + 1'b1;
            done_pending <= 1'b1;
        end else if (done_ack && !ram_wr_done && done_count != '0) begin
            done_count <= done_count - 1'b1;
            done_pending <= done_count > 1;
        end

        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            ram_cmd_valid <= 1'b0;
            cmd_room <= 1'b0;
            done_count <= '0;
            done_pending <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/dma_status_return.sv ====
// Statuses leave in acceptance order. At most 16 transfers are active at once.
`timescale 1ns/1ps
`default_nettype none

module dma_status_return (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire dma_sink_pkg::status_entry_t entry,
    input  wire logic                        entry_we,
    output logic                             sts_room,
    output logic                             slot_avail,
    input  wire logic                        done_pending,
    output logic                             done_ack,
    output dma_sink_pkg::desc_sts_t          desc_sts,
    output logic                             sts_valid
);

    dma_sink_pkg::status_entry_t                mem [2**dma_sink_pkg::STATUS_FIFO_AW];
    dma_sink_pkg::status_entry_t                head;
    logic [dma_sink_pkg::STATUS_FIFO_AW:0]      wr_ptr, rd_ptr, level;
    logic [dma_sink_pkg::STATUS_FIFO_AW:0]      active_count, active_next;
    logic                                       empty, pop;
    logic                                       in_xfer;
    logic                                       inc_active, dec_active;

    assign level = wr_ptr - rd_ptr;
    assign empty = wr_ptr == rd_ptr;
    assign head = mem[rd_ptr[dma_sink_pkg::STATUS_FIFO_AW-1:0]];

    // each record claims one completion
    assign pop = !empty && done_pending;
    assign done_ack = pop;

    assign inc_active = entry_we && !in_xfer;
    assign dec_active = pop && head.last;

    always_comb begin
        active_next = active_count;
        if (inc_active && !dec_active) begin
            active_next = active_count + 1'b1;
        end else if (dec_active && !inc_active) begin
            active_next = active_count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (entry_we) begin
            mem[wr_ptr[dma_sink_pkg::STATUS_FIFO_AW-1:0]] <= entry;
            wr_ptr <= wr_ptr + 1'b1;
            in_xfer <= !entry.last;
        end

        if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
            desc_sts.len <= head.len;
            desc_sts.tag <= head.tag;
        end

        sts_valid <= dec_active;
        sts_room <= level < 2**(dma_sink_pkg::STATUS_FIFO_AW-1);
        active_count <= active_next;
        slot_avail <= active_next < 2**dma_sink_pkg::STATUS_FIFO_AW;

        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            in_xfer <= 1'b0;
            sts_valid <= 1'b0;
            sts_room <= 1'b0;
            active_count <= '0;
            slot_avail <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/dma_client_axis_sink.sv ====
// Stream width equals the RAM word width. Destinations must be word aligned.
`timescale 1ns/1ps
`default_nettype none

module dma_client_axis_sink (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire dma_sink_pkg::desc_req_t         desc_req,
    input  wire logic                            desc_valid,
    output wire logic                            desc_ready,
    input  wire logic [dma_sink_pkg::DATA_W-1:0] s_tdata,
    input  wire logic [dma_sink_pkg::KEEP_W-1:0] s_tkeep,
    input  wire logic                            s_tlast,
    input  wire logic                            s_tvalid,
    output wire logic                            s_tready,
    output dma_sink_pkg::ram_cmd_t               ram_cmd,
    output wire logic                            ram_cmd_valid,
    input  wire logic                            ram_cmd_ready,
    input  wire logic                            ram_wr_done,
    output dma_sink_pkg::desc_sts_t              desc_sts,
    output wire logic                            sts_valid,
    input  wire logic                            enable
);

    dma_sink_pkg::job_t            job;
    wire logic                     job_valid;
    wire logic                     engine_idle;
    dma_sink_pkg::ram_cmd_t        cmd;
    wire logic                     cmd_valid;
    wire logic                     cmd_room;
    dma_sink_pkg::status_entry_t   entry;
    wire logic                     entry_we;
    wire logic                     sts_room;
    wire logic                     slot_avail;
    wire logic                     done_pending;
    wire logic                     done_ack;

    // decode stage
    dma_desc_decode u_decode (.*);

    // execute stage
    dma_write_engine u_engine (.*);
    dma_ram_write_port u_port (.*);

    // result stage
    dma_status_return u_status (.*);

endmodule

`default_nettype wire

// ==== bench/tb_dma_sink_assert.sv ====
// Checks apply outside reset, except the check of the first cycle after reset.
`timescale 1ns/1ps
`default_nettype none

module tb_dma_sink_assert (
    input wire logic                        clk,
    input wire logic                        rst,
    input wire logic                        enable,
    input wire logic                        desc_ready,
    input wire logic                        s_tready,
    input wire dma_sink_pkg::ram_cmd_t      ram_cmd,
    input wire logic                        ram_cmd_valid,
    input wire logic                        ram_cmd_ready,
    input wire logic                        sts_valid,
    input wire logic                        job_valid,
    input wire logic                        done_ack
);

    int fail_count = 0;

    cmd_held: assert property (@(posedge clk) disable iff (rst)
        ram_cmd_valid && !ram_cmd_ready |=> $stable(ram_cmd))
        else begin
            fail_count++;
            $error("ram_cmd changed while the RAM stalled it");
        end

    sts_single: assert property (@(posedge clk) disable iff (rst) sts_valid |=> !sts_valid)
        else begin
            fail_count++;
            $error("sts_valid held for two cycles");
        end

    enable_gates: assert property (@(posedge clk) disable iff (rst) !enable |=> !desc_ready)
        else begin
            fail_count++;
            $error("desc_ready high after enable was low");
        end

    reset_quiet: assert property (@(posedge clk)
        $fell(rst) |-> !(desc_ready || s_tready || ram_cmd_valid || sts_valid
                         || job_valid || done_ack))
        else begin
            fail_count++;
            $error("control output high in the first cycle after reset");
        end

endmodule

bind dma_client_axis_sink tb_dma_sink_assert u_check (.*);

`default_nettype wire

// ==== bench/tb_dma_sink.sv ====
// The RAM model completes each accepted write two cycles later. Every wait gives up after 2000 cycles.
`timescale 1ns/1ps
`default_nettype none

module tb_dma_sink;

    logic                            clk;
    logic                            rst;
    logic                            enable;
    dma_sink_pkg::desc_req_t         desc_req;
    logic                            desc_valid;
    logic                            desc_ready;
    logic [dma_sink_pkg::DATA_W-1:0] s_tdata;
    logic [dma_sink_pkg::KEEP_W-1:0] s_tkeep;
    logic                            s_tlast;
    logic                            s_tvalid;
    logic                            s_tready;
    dma_sink_pkg::ram_cmd_t          ram_cmd;
    logic                            ram_cmd_valid;
    logic                            ram_cmd_ready;
    logic                            ram_wr_done;
    dma_sink_pkg::desc_sts_t         desc_sts;
    logic                            sts_valid;

    logic [dma_sink_pkg::DATA_W-1:0] ram_mem [2**dma_sink_pkg::WORD_ADDR_W];
    logic [dma_sink_pkg::DATA_W-1:0] exp_mem [2**dma_sink_pkg::WORD_ADDR_W];
    dma_sink_pkg::desc_sts_t         exp_sts [$];
    string                           name_q [$];
    dma_sink_pkg::desc_sts_t         exp_head;
    string                           head_name;
    logic                            exp_avail;
    string                           test_name;
    logic [15:0]                     lfsr_state;
    logic                            random_mode;
    logic                            stall_bit;
    logic                            ready_bit;
    logic [1:0]                      done_sr;
    int                              wait_limit;
    int                              sts_errors;
    int                              mem_errors;
    int                              timeouts;

    dma_client_axis_sink uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hb400;
        end
        return out;
    endfunction

    function automatic logic [31:0] fill_word(input logic [13:0] a);
        return {2'b10, a, 2'b01, ~a};
    endfunction

    // lanes of beat b that the requested length still covers
    function automatic logic [3:0] beat_mask(input int b, input int words, input logic [15:0] len);
        if (b == words - 1 && len[1:0] != 2'd0) begin
            return 4'((4'b1 << len[1:0]) - 1);
        end
        return 4'hf;
    endfunction

    function automatic logic [15:0] expected_len(input logic [15:0] len, input int beats,
                                                 input logic [3:0] last_keep);
        int words;
        int n;
        logic [3:0] keep;
        words = (len + 3) / 4;
        if (beats > words) begin
            return len;
        end
        keep = last_keep & beat_mask(beats - 1, words, len);
        n = 0;
        for (int i = 0; i < 4; i++) begin
            if (keep[i] && n == i) begin
                n++;
            end
        end
        return 16'(4 * (beats - 1) + n);
    endfunction

    function automatic void refresh_head();
        exp_avail = exp_sts.size() > 0;
        if (exp_avail) begin
            exp_head = exp_sts[0];
            head_name = name_q[0];
        end
    endfunction

    // RAM model, ready and stall bits are drawn at the edge and driven 1 ns later
    always @(posedge clk) begin
        if (!rst && ram_cmd_valid && ram_cmd_ready) begin
            for (int i = 0; i < 4; i++) begin
                if (ram_cmd.be[i]) begin
                    ram_mem[ram_cmd.addr][8*i +: 8] = ram_cmd.data[8*i +: 8];
                end
            end
        end
        done_sr = {done_sr[0], !rst && ram_cmd_valid && ram_cmd_ready};
        ready_bit = random_mode ? lfsr_bit() : 1'b1;
        stall_bit = random_mode ? lfsr_bit() : 1'b0;
        #1;
        ram_wr_done = done_sr[1];
        ram_cmd_ready = ready_bit;
    end

    // retire the head 1 ns after the edge where its pulse was sampled
    always @(posedge clk) begin
        if (!rst && sts_valid && exp_sts.size() > 0) begin
            #1;
            void'(exp_sts.pop_front());
            void'(name_q.pop_front());
            refresh_head();
        end
    end

    status_present: assert property (@(posedge clk) disable iff (rst) sts_valid |-> exp_avail)
        else begin
            sts_errors++;
            $display("status pulse with no transfer outstanding, tag %h",
                     $sampled(desc_sts.tag));
        end

    status_match: assert property (@(posedge clk) disable iff (rst)
        sts_valid && exp_avail |-> desc_sts == exp_head)
        else begin
            sts_errors++;
            $display("CHECK FAILED %s: status expected %h actual %h",
                     head_name, exp_head, $sampled(desc_sts));
        end

    task automatic finish_run();
        int protocol_errors;
        protocol_errors = uut.u_check.fail_count;
        $display("errors: status %0d, memory %0d, timeouts %0d, protocol %0d",
                 sts_errors, mem_errors, timeouts, protocol_errors);
        if (sts_errors + mem_errors + timeouts + protocol_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout while waiting for %s in test %s", what, test_name);
        finish_run();
    endtask

    task automatic send_beat(input logic [31:0] data, input logic [3:0] keep, input logic last);
        int waited;
        waited = 0;
        while (random_mode && stall_bit && waited < wait_limit) begin
            s_tvalid = 1'b0;
            @(posedge clk);
            #1;
            waited++;
        end
        s_tdata = data;
        s_tkeep = keep;
        s_tlast = last;
        s_tvalid = 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!s_tready && waited < wait_limit);
        if (!s_tready) begin
            report_timeout("a stream beat");
        end
        #1;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
    endtask

    // one descriptor and its stream, tlast on the final beat
    task automatic xfer(input logic [15:0] addr, input logic [15:0] len, input logic [7:0] tag,
                        input int beats, input logic [3:0] last_keep);
        dma_sink_pkg::desc_sts_t sts;
        logic [31:0] data;
        logic [3:0] keep;
        int words;
        int waited;
        words = (len + 3) / 4;
        sts.len = expected_len(len, beats, last_keep);
        sts.tag = tag;
        exp_sts.push_back(sts);
        name_q.push_back(test_name);
        refresh_head();
        desc_req.dst_addr = addr;
        desc_req.len = len;
        desc_req.tag = tag;
        desc_valid = 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!desc_ready && waited < wait_limit);
        if (!desc_ready) begin
            report_timeout("descriptor acceptance");
        end
        #1;
        desc_valid = 1'b0;
        for (int b = 0; b < beats; b++) begin
            data = {tag, 8'(b), ~tag, 8'hc3 ^ 8'(b)};
            keep = (b == beats - 1) ? last_keep : 4'hf;
            if (b < words) begin
                for (int i = 0; i < 4; i++) begin
                    if ((keep & beat_mask(b, words, len)) & (4'b1 << i)) begin
                        exp_mem[14'(addr[15:2] + b)][8*i +: 8] = data[8*i +: 8];
                    end
                end
            end
            send_beat(data, keep, b == beats - 1);
        end
    endtask

    task automatic run_backpressure();
        int lens [6] = '{24, 13, 40, 7, 20, 16};
        int beats [6] = '{6, 4, 3, 5, 5, 4};
        logic [3:0] keeps [6] = '{4'hf, 4'hf, 4'h3, 4'hf, 4'h1, 4'hf};
        random_mode = 1'b1;
        for (int i = 0; i < 6; i++) begin
            xfer(16'(16'h1000 + i * 64), 16'(lens[i]), 8'(8'h60 + i), beats[i], keeps[i]);
        end
        random_mode = 1'b0;
    endtask

    task automatic wait_statuses();
        int waited;
        waited = 0;
        while (exp_sts.size() > 0 && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (exp_sts.size() > 0) begin
            report_timeout("the remaining status pulses");
        end
    endtask

    initial begin
        rst = 1'b1;
        enable = 1'b1;
        desc_req = '0;
        desc_valid = 1'b0;
        s_tdata = '0;
        s_tkeep = '0;
        s_tlast = 1'b0;
        s_tvalid = 1'b0;
        ram_cmd_ready = 1'b0;
        ram_wr_done = 1'b0;
        lfsr_state = 16'd2522;
        random_mode = 1'b0;
        stall_bit = 1'b0;
        done_sr = '0;
        wait_limit = 2000;
        sts_errors = 0;
        mem_errors = 0;
        timeouts = 0;
        exp_avail = 1'b0;
        test_name = "reset";
        for (int a = 0; a < 2**dma_sink_pkg::WORD_ADDR_W; a++) begin
            ram_mem[a] = fill_word(14'(a));
            exp_mem[a] = ram_mem[a];
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name = "full_transfer";
        xfer(16'h0100, 16'd16, 8'h11, 4, 4'hf);
        test_name = "trimmed_beat";
        xfer(16'h0200, 16'd10, 8'h22, 3, 4'hf);
        test_name = "early_tlast";
        xfer(16'h0300, 16'd32, 8'h33, 2, 4'h7);
        test_name = "excess_data";
        xfer(16'h0400, 16'd8, 8'h44, 4, 4'hf);
        xfer(16'h0500, 16'd8, 8'h45, 2, 4'hf);
        test_name = "backpressure";
        run_backpressure();

        test_name = "enable";
        enable = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        fork
            xfer(16'h2000, 16'd12, 8'h7e, 3, 4'hf);
            begin
                repeat (12) @(posedge clk);
                #1;
                enable = 1'b1;
            end
        join

        wait_statuses();
        repeat (4) @(posedge clk);
        for (int a = 0; a < 2**dma_sink_pkg::WORD_ADDR_W; a++) begin
            if (ram_mem[a] !== exp_mem[a]) begin
                mem_errors++;
                $display("CHECK FAILED memory_image word %h: expected %h actual %h",
                         14'(a), exp_mem[a], ram_mem[a]);
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== project.f ====
design/dma_sink_pkg.sv
design/dma_desc_decode.sv
design/dma_write_engine.sv
design/dma_ram_write_port.sv
design/dma_status_return.sv
design/dma_client_axis_sink.sv
bench/tb_dma_sink_assert.sv
bench/tb_dma_sink.sv

// ==== Bender.yml ====
package:
  name: dma_client_axis_sink

sources:
  - design/dma_sink_pkg.sv
  - design/dma_desc_decode.sv
  - design/dma_write_engine.sv
  - design/dma_ram_write_port.sv
  - design/dma_status_return.sv
  - design/dma_client_axis_sink.sv
  - target: test
    files:
      - bench/tb_dma_sink_assert.sv
      - bench/tb_dma_sink.sv
